// File: id_stage.f
+incdir+logic
logic/id_pkg.sv
logic/id_stage_ctrl.sv
logic/id_decoder.sv
logic/id_gpr_file.sv
logic/id_branch_unit.sv
logic/id_stage.sv
verif/id_stage_asserts.sv
verif/id_stage_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module id_stage_tb -f id_stage.f -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build returned status $status"
  exit $status
fi

./obj_dir/Vid_stage_tb
status=$?
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit $status
fi

exit 0

// File: verif/id_stage_tb.sv
// fixed instruction table driven on the falling edge and only x0 to x5 are preloaded
`default_nettype none

`include "id_cfg.svh"

module id_stage_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import id_pkg::*;

  typedef struct packed {
    inst_t      inst;
    xlen_t      pc;
    xlen_t      fetch_pc;  // fetch pc shown while the row is held
    gpr_addr_t  haz;       // 0 for no hazard
    logic [3:0] hold;      // cycles of i_es_allowin low
    gpr_addr_t  rd;
    xlen_t      imm;
    alu_op_t    alu_op;
    logic [3:0] ctrl;      // src2_imm gpr_wen mem_ren mem_wen
    logic       invalid;
    logic       taken;
  } row_t;

  localparam inst_t follower_inst = 32'h00100313;  // addi x6, x0, 1

  logic      i_clk;
  logic      i_arst_n;
  logic      i_fs_valid;
  inst_t     i_fs_inst;
  xlen_t     i_fs_pc;
  logic      o_ds_allowin;
  logic      i_es_allowin;
  logic      o_es_valid;
  xlen_t     o_es_rs1_data;
  xlen_t     o_es_rs2_data;
  xlen_t     o_es_imm;
  xlen_t     o_es_pc;
  gpr_addr_t o_es_rd;
  alu_op_t   o_es_alu_op;
  logic      o_es_alu_src2_imm;
  logic      o_es_gpr_wen;
  logic      o_es_mem_ren;
  logic      o_es_mem_wen;
  logic      o_es_invalid;
  logic      o_br_taken;
  xlen_t     o_br_target;
  logic      i_ws_gpr_wen;
  gpr_addr_t i_ws_gpr_waddr;
  xlen_t     i_ws_gpr_wdata;
  gpr_addr_t i_es_rd;
  gpr_addr_t i_ms_rd;
  gpr_addr_t i_ws_rd;

  row_t   rows [$];
  xlen_t  gpr_model [`ID_NUM_GPRS];
  integer seed;
  int     cycle_count = 0;
  int     cycle_limit = 40;

  id_stage dut (
    .i_clk (i_clk), .i_arst_n (i_arst_n),
    .i_fs_valid (i_fs_valid), .i_fs_inst (i_fs_inst), .i_fs_pc (i_fs_pc),
    .o_ds_allowin (o_ds_allowin), .i_es_allowin (i_es_allowin), .o_es_valid (o_es_valid),
    .o_es_rs1_data (o_es_rs1_data), .o_es_rs2_data (o_es_rs2_data),
    .o_es_imm (o_es_imm), .o_es_pc (o_es_pc), .o_es_rd (o_es_rd),
    .o_es_alu_op (o_es_alu_op), .o_es_alu_src2_imm (o_es_alu_src2_imm),
    .o_es_gpr_wen (o_es_gpr_wen), .o_es_mem_ren (o_es_mem_ren),
    .o_es_mem_wen (o_es_mem_wen), .o_es_invalid (o_es_invalid),
    .o_br_taken (o_br_taken), .o_br_target (o_br_target),
    .i_ws_gpr_wen (i_ws_gpr_wen), .i_ws_gpr_waddr (i_ws_gpr_waddr),
    .i_ws_gpr_wdata (i_ws_gpr_wdata),
    .i_es_rd (i_es_rd), .i_ms_rd (i_ms_rd), .i_ws_rd (i_ws_rd)
  );

  bind id_stage id_stage_asserts u_asserts (
    .i_clk (i_clk), .i_arst_n (i_arst_n), .i_es_allowin (i_es_allowin),
    .o_es_valid (o_es_valid), .o_br_taken (o_br_taken),
    .o_es_pc (o_es_pc), .o_es_rd (o_es_rd)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Simulation failed");
      $fatal(1, "timeout after %0d cycles, the stage stopped making progress", cycle_count);
    end
  end

  task automatic check(input string name, input xlen_t actual, input xlen_t expected);
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
      $display("Simulation failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic add_row(input inst_t inst, input xlen_t pc, input xlen_t fetch_pc,
                         input gpr_addr_t haz, input logic [3:0] hold, input gpr_addr_t rd,
                         input xlen_t imm, input alu_op_t alu_op, input logic [3:0] ctrl,
                         input logic invalid, input logic taken);
    rows.push_back({inst, pc, fetch_pc, haz, hold, rd, imm, alu_op, ctrl, invalid, taken});
  endtask

  task automatic build_table();
    // inst, pc, fetch pc, hazard, hold, rd, imm, alu op, controls, invalid, taken
    add_row(32'h002081b3, 64'h1000, 64'h1004, 5'd1, 4'd0,
            5'd3, 64'd0, `ID_ALU_ADD, 4'b0100, 1'b0, 1'b0);  // add x3, x1, x2
    add_row(32'h40328233, 64'h1004, 64'h1008, 5'd5, 4'd0,
            5'd4, 64'd0, `ID_ALU_SUB, 4'b0100, 1'b0, 1'b0);  // sub x4, x5, x3
    add_row(32'hff010293, 64'h1008, 64'h100c, 5'd0, 4'd2,
            5'd5, -64'sd16, `ID_ALU_ADD, 4'b1100, 1'b0, 1'b0);  // addi x5, x2, -16
    add_row(32'h0080b303, 64'h100c, 64'h1010, 5'd1, 4'd0,
            5'd6, 64'd8, `ID_ALU_ADD, 4'b1110, 1'b0, 1'b0);  // ld x6, 8(x1)
    add_row(32'h0021b823, 64'h1010, 64'h1014, 5'd2, 4'd1,
            5'd0, 64'd16, `ID_ALU_ADD, 4'b1001, 1'b0, 1'b0);  // sd x2, 16(x3)
    add_row(32'h000003b3, 64'h1014, 64'h1018, 5'd0, 4'd0,
            5'd7, 64'd0, `ID_ALU_ADD, 4'b0100, 1'b0, 1'b0);  // add x7, x0, x0
    add_row(32'h02108063, 64'h1100, 64'h1104, 5'd0, 4'd0,
            5'd0, 64'd32, `ID_ALU_ADD, 4'b0000, 1'b0, 1'b1);  // beq x1, x1, +32
    add_row(32'h02109063, 64'h1200, 64'h1204, 5'd0, 4'd0,
            5'd0, 64'd32, `ID_ALU_ADD, 4'b0000, 1'b0, 1'b0);  // bne x1, x1, +32
    add_row(32'hfe210ce3, 64'h1300, 64'h12f8, 5'd0, 4'd0,
            5'd0, -64'sd8, `ID_ALU_ADD, 4'b0000, 1'b0, 1'b0);  // fetch already at target
    add_row(32'h001000ef, 64'h1400, 64'h1404, 5'd0, 4'd3,
            5'd1, 64'h800, `ID_ALU_LINK, 4'b0100, 1'b0, 1'b1);  // jal x1, +2048
    add_row(32'h005182e7, 64'h1500, 64'h1504, 5'd0, 4'd0,
            5'd5, 64'd5, `ID_ALU_LINK, 4'b0100, 1'b0, 1'b1);  // jalr x5, 5(x3)
    add_row(32'h000010b7, 64'h1600, 64'h1604, 5'd0, 4'd1,
            5'd0, 64'd0, `ID_ALU_ADD, 4'b0000, 1'b1, 1'b0);  // lui, not supported
    add_row(32'h022081b3, 64'h1604, 64'h1608, 5'd0, 4'd0,
            5'd0, 64'd0, `ID_ALU_ADD, 4'b0000, 1'b1, 1'b0);  // mul, not supported
  endtask

  function automatic logic uses_rs1(inst_t w);
    case (w[6:0])
      `ID_OPC_OP, `ID_OPC_OP_IMM, `ID_OPC_LOAD,
      `ID_OPC_STORE, `ID_OPC_BRANCH, `ID_OPC_JALR: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic uses_rs2(inst_t w);
    case (w[6:0])
      `ID_OPC_OP, `ID_OPC_STORE, `ID_OPC_BRANCH: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // jalr is register relative with bit 0 cleared and the rest pc relative
  function automatic xlen_t branch_target(inst_t w, xlen_t pc, xlen_t imm);
    xlen_t sum;
    if (w[6:0] == `ID_OPC_JALR) begin
      sum = gpr_model[w[19:15]] + imm;
      return {sum[`ID_XLEN-1:1], 1'b0};
    end
    return pc + imm;
  endfunction

  task automatic preload_gprs();
    xlen_t value;
    for (int i = 0; i < 6; i++) begin
      @(negedge i_clk);
      value          = {$random(seed), $random(seed)};
      i_ws_gpr_wen   = 1'b1;
      i_ws_gpr_waddr = gpr_addr_t'(i);
      i_ws_gpr_wdata = value;
      if (i != 0) begin
        gpr_model[i] = value;  // x0 write must be dropped
      end
    end
    @(negedge i_clk);
    i_ws_gpr_wen = 1'b0;
  endtask

  task automatic check_fields(input row_t r);
    check("o_es_valid", xlen_t'(o_es_valid), 64'd1);
    check("o_es_pc", o_es_pc, r.pc);
    check("o_es_rd", xlen_t'(o_es_rd), xlen_t'(r.rd));
    check("o_es_imm", o_es_imm, r.imm);
    check("o_es_alu_op", xlen_t'(o_es_alu_op), xlen_t'(r.alu_op));
    check("o_es_alu_src2_imm", xlen_t'(o_es_alu_src2_imm), xlen_t'(r.ctrl[3]));
    check("o_es_gpr_wen", xlen_t'(o_es_gpr_wen), xlen_t'(r.ctrl[2]));
    check("o_es_mem_ren", xlen_t'(o_es_mem_ren), xlen_t'(r.ctrl[1]));
    check("o_es_mem_wen", xlen_t'(o_es_mem_wen), xlen_t'(r.ctrl[0]));
    check("o_es_invalid", xlen_t'(o_es_invalid), xlen_t'(r.invalid));
    check("o_br_taken", xlen_t'(o_br_taken), xlen_t'(r.taken));
    if (uses_rs1(r.inst)) begin
      check("o_es_rs1_data", o_es_rs1_data, gpr_model[r.inst[19:15]]);
    end
    if (uses_rs2(r.inst)) begin
      check("o_es_rs2_data", o_es_rs2_data, gpr_model[r.inst[24:20]]);
    end
    if (r.taken) begin
      check("o_br_target", o_br_target, branch_target(r.inst, r.pc, r.imm));
    end
  endtask

  task automatic run_row(input row_t r, input int idx);
    @(negedge i_clk);
    i_fs_valid   = 1'b1;
    i_fs_inst    = r.inst;
    i_fs_pc      = r.pc;
    i_es_allowin = 1'b1;
    #1;
    while (!o_ds_allowin) begin
      @(negedge i_clk);
      #1;
    end
    @(negedge i_clk);
    i_fs_valid = 1'b0;
    i_fs_pc    = r.fetch_pc;
    if (r.haz != '0) begin
      if (idx[0]) begin
        i_ms_rd = r.haz;
      end else begin
        i_es_rd = r.haz;
      end
      repeat (2) begin
        #1;
        check("o_es_valid", xlen_t'(o_es_valid), 64'd0);
        check("o_ds_allowin", xlen_t'(o_ds_allowin), 64'd0);
        check("o_br_taken", xlen_t'(o_br_taken), 64'd0);
        @(negedge i_clk);
      end
      i_es_rd = '0;
      i_ms_rd = '0;
    end
    repeat (r.hold) begin
      i_es_allowin = 1'b0;
      #1;
      check("o_ds_allowin", xlen_t'(o_ds_allowin), 64'd0);
      check_fields(r);
      @(negedge i_clk);
    end
    // transfer while the next fetched word arrives on the same edge
    i_es_allowin = 1'b1;
    i_fs_valid   = 1'b1;
    i_fs_inst    = follower_inst;
    #1;
    check("o_ds_allowin", xlen_t'(o_ds_allowin), 64'd1);
    check_fields(r);
    @(negedge i_clk);
    i_fs_valid = 1'b0;
    #1;
    check("o_es_valid", xlen_t'(o_es_valid), 64'd1);
    check("o_br_taken", xlen_t'(o_br_taken), 64'd0);
    check("o_es_rd", xlen_t'(o_es_rd), r.taken ? 64'd0 : 64'd6);
    check("o_es_gpr_wen", xlen_t'(o_es_gpr_wen), xlen_t'(!r.taken));
    check("o_es_mem_ren", xlen_t'(o_es_mem_ren), 64'd0);
    check("o_es_mem_wen", xlen_t'(o_es_mem_wen), 64'd0);
    check("o_es_invalid", xlen_t'(o_es_invalid), 64'd0);
  endtask

  initial begin
    i_arst_n       = 1'b0;
    i_fs_valid     = 1'b0;
    i_fs_inst      = '0;
    i_fs_pc        = '0;
    i_es_allowin   = 1'b1;
    i_ws_gpr_wen   = 1'b0;
    i_ws_gpr_waddr = '0;
    i_ws_gpr_wdata = '0;
    i_es_rd        = '0;
    i_ms_rd        = '0;
    i_ws_rd        = '0;
    seed           = 32'h3871586d;
    for (int i = 0; i < `ID_NUM_GPRS; i++) begin
      gpr_model[i] = '0;
    end
    build_table();
    cycle_limit = 20 * rows.size() + 40;

    repeat (4) @(negedge i_clk);
    #1;
    check("o_es_valid", xlen_t'(o_es_valid), 64'd0);
    check("o_br_taken", xlen_t'(o_br_taken), 64'd0);
    i_arst_n = 1'b1;

    preload_gprs();
    foreach (rows[i]) begin
      run_row(rows[i], i);
    end

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/id_stage_asserts.sv
// assumes the single stage clock and sees only the id_stage ports it is bound to
`default_nettype none

module id_stage_asserts (
  input wire                     i_clk,
  input wire                     i_arst_n,
  input wire                     i_es_allowin,
  input wire                     o_es_valid,
  input wire                     o_br_taken,
  input wire id_pkg::xlen_t      o_es_pc,
  input wire id_pkg::gpr_addr_t  o_es_rd
);

  timeunit 1ns;
  timeprecision 1ps;

  valid_low_in_reset: assert property (@(posedge i_clk) !i_arst_n |-> !o_es_valid)
    else $error("o_es_valid high while reset is asserted");

  redirect_needs_valid: assert property (
    @(posedge i_clk) disable iff (!i_arst_n) o_br_taken |-> o_es_valid)
    else $error("o_br_taken high without o_es_valid");

  // execute holding off freezes what it sees
  hold_under_backpressure: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    (o_es_valid && !i_es_allowin) |=> ($stable(o_es_pc) && $stable(o_es_rd)))
    else $error("o_es_pc or o_es_rd changed while i_es_allowin was low");

endmodule

`default_nettype wire

// File: logic/id_stage.sv
// decode stage top with valid/allowin on both sides and redirect resolved here
`default_nettype none

module id_stage (
  input  wire                     i_clk,
  input  wire                     i_arst_n,
  // fetch to decode
  input  wire                     i_fs_valid,
  input  wire id_pkg::inst_t      i_fs_inst,
  input  wire id_pkg::xlen_t      i_fs_pc,
  output wire                     o_ds_allowin,
  // decode to execute
  input  wire                     i_es_allowin,
  output wire                     o_es_valid,
  output wire id_pkg::xlen_t      o_es_rs1_data,
  output wire id_pkg::xlen_t      o_es_rs2_data,
  output wire id_pkg::xlen_t      o_es_imm,
  output wire id_pkg::xlen_t      o_es_pc,
  output wire id_pkg::gpr_addr_t  o_es_rd,
  output wire id_pkg::alu_op_t    o_es_alu_op,
  output wire                     o_es_alu_src2_imm,
  output wire                     o_es_gpr_wen,
  output wire                     o_es_mem_ren,
  output wire                     o_es_mem_wen,
  output wire                     o_es_invalid,
  // redirect to fetch
  output wire                     o_br_taken,
  output wire id_pkg::xlen_t      o_br_target,
  // write-back
  input  wire                     i_ws_gpr_wen,
  input  wire id_pkg::gpr_addr_t  i_ws_gpr_waddr,
  input  wire id_pkg::xlen_t      i_ws_gpr_wdata,
  // destinations still in flight
  input  wire id_pkg::gpr_addr_t  i_es_rd,
  input  wire id_pkg::gpr_addr_t  i_ms_rd,
  input  wire id_pkg::gpr_addr_t  i_ws_rd
);

  import id_pkg::*;

  wire inst_t     ds_inst;
  wire gpr_addr_t rs1;
  wire gpr_addr_t rs2;
  wire            br_en;
  wire            br_ne;
  wire            jal;
  wire            jalr;
  wire            br_sel;

  id_stage_ctrl u_ctrl (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_fs_valid   (i_fs_valid),
    .i_fs_inst    (i_fs_inst),
    .i_fs_pc      (i_fs_pc),
    .i_es_allowin (i_es_allowin),
    .i_es_rd      (i_es_rd),
    .i_ms_rd      (i_ms_rd),
    .i_ws_rd      (i_ws_rd),
    .i_rs1        (rs1),
    .i_rs2        (rs2),
    .i_br_sel     (br_sel),
    .i_br_target  (o_br_target),
    .o_ds_allowin (o_ds_allowin),
    .o_es_valid   (o_es_valid),
    .o_br_taken   (o_br_taken),
    .o_ds_inst    (ds_inst),
    .o_ds_pc      (o_es_pc)       // held pc goes straight to execute
  );

  id_decoder u_dec (
    .i_inst         (ds_inst),
    .o_rs1          (rs1),
    .o_rs2          (rs2),
    .o_rd           (o_es_rd),
    .o_imm          (o_es_imm),
    .o_alu_op       (o_es_alu_op),
    .o_alu_src2_imm (o_es_alu_src2_imm),
    .o_gpr_wen      (o_es_gpr_wen),
    .o_mem_ren      (o_es_mem_ren),
    .o_mem_wen      (o_es_mem_wen),
    .o_br_en        (br_en),
    .o_br_ne        (br_ne),
    .o_jal          (jal),
    .o_jalr         (jalr),
    .o_invalid      (o_es_invalid)
  );

  id_gpr_file u_gprs (
    .i_clk    (i_clk),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .o_rdata1 (o_es_rs1_data),
    .o_rdata2 (o_es_rs2_data),
    .i_wen    (i_ws_gpr_wen),
    .i_waddr  (i_ws_gpr_waddr),
    .i_wdata  (i_ws_gpr_wdata)
  );

  id_branch_unit u_bru (
    .i_pc        (o_es_pc),
    .i_imm       (o_es_imm),
    .i_rs1_data  (o_es_rs1_data),
    .i_rs2_data  (o_es_rs2_data),
    .i_br_en     (br_en),
    .i_br_ne     (br_ne),
    .i_jal       (jal),
    .i_jalr      (jalr),
    .o_br_sel    (br_sel),
    .o_br_target (o_br_target)
  );

endmodule

`default_nettype wire

// File: logic/id_branch_unit.sv
// resolves beq bne jal and jalr in decode with a full 64-bit compare
`default_nettype none

module id_branch_unit (
  input  wire id_pkg::xlen_t  i_pc,
  input  wire id_pkg::xlen_t  i_imm,
  input  wire id_pkg::xlen_t  i_rs1_data,
  input  wire id_pkg::xlen_t  i_rs2_data,
  input  wire                 i_br_en,
  input  wire                 i_br_ne,
  input  wire                 i_jal,
  input  wire                 i_jalr,
  output logic                o_br_sel,
  output id_pkg::xlen_t       o_br_target
);

  import id_pkg::*;

  logic  rs_equal;
  logic  cond_met;
  xlen_t pc_rel_target;
  xlen_t jalr_sum;

  assign rs_equal = (i_rs1_data == i_rs2_data);
  assign cond_met = i_br_ne ? !rs_equal : rs_equal;

  // jumps always redirect
  assign o_br_sel = (i_br_en && cond_met) || i_jal || i_jalr;

  assign pc_rel_target = i_pc + i_imm;
  assign jalr_sum      = i_rs1_data + i_imm;

  always_comb begin
    if (i_jalr) begin
      o_br_target = {jalr_sum[$bits(xlen_t)-1:1], 1'b0};  // bit 0 cleared
    end else begin
      o_br_target = pc_rel_target;
    end
  end

endmodule

`default_nettype wire

// File: logic/id_gpr_file.sv
// x0 reads as zero and reads have no write bypass since the stage stalls on write-back
`default_nettype none

`include "id_cfg.svh"

module id_gpr_file (
  input  wire                     i_clk,
  // read ports
  input  wire id_pkg::gpr_addr_t  i_raddr1,
  input  wire id_pkg::gpr_addr_t  i_raddr2,
  output id_pkg::xlen_t           o_rdata1,
  output id_pkg::xlen_t           o_rdata2,
  // write-back port
  input  wire                     i_wen,
  input  wire id_pkg::gpr_addr_t  i_waddr,
  input  wire id_pkg::xlen_t      i_wdata
);

  import id_pkg::*;

  xlen_t gpr_q [`ID_NUM_GPRS];  // entry 0 never written

  always_ff @(posedge i_clk) begin
    if (i_wen && (i_waddr != '0)) begin
      gpr_q[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : gpr_q[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : gpr_q[i_raddr2];

endmodule

`default_nettype wire

// File: logic/id_decoder.sv
// decodes add sub addi ld sd beq bne jal jalr and anything else except the zero word is invalid
`default_nettype none

`include "id_cfg.svh"

module id_decoder (
  input  wire id_pkg::inst_t  i_inst,
  output id_pkg::gpr_addr_t   o_rs1,
  output id_pkg::gpr_addr_t   o_rs2,
  output id_pkg::gpr_addr_t   o_rd,
  output id_pkg::xlen_t       o_imm,
  output id_pkg::alu_op_t     o_alu_op,
  output logic                o_alu_src2_imm,
  output logic                o_gpr_wen,
  output logic                o_mem_ren,
  output logic                o_mem_wen,
  output logic                o_br_en,
  output logic                o_br_ne,
  output logic                o_jal,
  output logic                o_jalr,
  output logic                o_invalid
);

  import id_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_j;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{(`ID_XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(`ID_XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(`ID_XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7],
                  i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_j = {{(`ID_XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12],
                  i_inst[20], i_inst[30:21], 1'b0};

  // raw fields, hazard compare uses them as is
  assign o_rs1 = i_inst[19:15];
  assign o_rs2 = i_inst[24:20];
  assign o_rd  = o_gpr_wen ? i_inst[11:7] : '0;  // zero when nothing is written

  always_comb begin
    o_imm          = '0;
    o_alu_op       = `ID_ALU_ADD;
    o_alu_src2_imm = 1'b0;
    o_gpr_wen      = 1'b0;
    o_mem_ren      = 1'b0;
    o_mem_wen      = 1'b0;
    o_br_en        = 1'b0;
    o_br_ne        = 1'b0;
    o_jal          = 1'b0;
    o_jalr         = 1'b0;
    o_invalid      = 1'b0;
    case (opcode)
      `ID_OPC_OP: begin
        if (funct3 == `ID_F3_ADD && funct7 == 7'b0) begin
          o_gpr_wen = 1'b1;
        end else if (funct3 == `ID_F3_ADD && funct7 == `ID_F7_SUB) begin
          o_gpr_wen = 1'b1;
          o_alu_op  = `ID_ALU_SUB;
        end else begin
          o_invalid = 1'b1;
        end
      end
      `ID_OPC_OP_IMM: begin
        o_invalid = (funct3 != `ID_F3_ADD);
        o_gpr_wen = !o_invalid;
        o_alu_src2_imm = !o_invalid;
        o_imm = o_invalid ? '0 : imm_i;
      end
      `ID_OPC_LOAD: begin
        o_invalid = (funct3 != `ID_F3_D);
        o_gpr_wen = !o_invalid;
        o_mem_ren = !o_invalid;
        o_alu_src2_imm = !o_invalid;  // address is rs1 + imm
        o_imm = o_invalid ? '0 : imm_i;
      end
      `ID_OPC_STORE: begin
        o_invalid = (funct3 != `ID_F3_D);
        o_mem_wen = !o_invalid;
        o_alu_src2_imm = !o_invalid;
        o_imm = o_invalid ? '0 : imm_s;
      end
      `ID_OPC_BRANCH: begin
        o_invalid = (funct3 != `ID_F3_BEQ) && (funct3 != `ID_F3_BNE);
        o_br_en = !o_invalid;
        o_br_ne = (funct3 == `ID_F3_BNE);
        o_imm = o_invalid ? '0 : imm_b;
      end
      `ID_OPC_JAL: begin
        o_jal     = 1'b1;
        o_gpr_wen = 1'b1;
        o_alu_op  = `ID_ALU_LINK;
        o_imm     = imm_j;
      end
      `ID_OPC_JALR: begin
        o_invalid = (funct3 != `ID_F3_ADD);
        o_jalr    = !o_invalid;
        o_gpr_wen = !o_invalid;
        o_alu_op  = o_invalid ? `ID_ALU_ADD : `ID_ALU_LINK;
        o_imm     = o_invalid ? '0 : imm_i;
      end
      default: o_invalid = (i_inst != '0);  // zero word is a bubble
    endcase
  end

endmodule

`default_nettype wire

// File: logic/id_stage_ctrl.sv
// one entry stage register and the zero word it resets to or squashes to is a bubble
`default_nettype none

module id_stage_ctrl (
  input  wire                     i_clk,
  input  wire                     i_arst_n,
  // fetch side
  input  wire                     i_fs_valid,
  input  wire id_pkg::inst_t      i_fs_inst,
  input  wire id_pkg::xlen_t      i_fs_pc,     // also the pc being fetched now
  input  wire                     i_es_allowin,
  // hazard compare
  input  wire id_pkg::gpr_addr_t  i_es_rd,
  input  wire id_pkg::gpr_addr_t  i_ms_rd,
  input  wire id_pkg::gpr_addr_t  i_ws_rd,
  input  wire id_pkg::gpr_addr_t  i_rs1,
  input  wire id_pkg::gpr_addr_t  i_rs2,
  // from branch unit
  input  wire                     i_br_sel,
  input  wire id_pkg::xlen_t      i_br_target,
  output logic                    o_ds_allowin,
  output logic                    o_es_valid,
  output logic                    o_br_taken,
  output id_pkg::inst_t           o_ds_inst,
  output id_pkg::xlen_t           o_ds_pc
);

  import id_pkg::*;

  logic ds_valid;
  logic ds_stall;

  // a later stage still owes this register
  function automatic logic rd_hit(gpr_addr_t rd, gpr_addr_t rs1, gpr_addr_t rs2);
    return (rd != '0) && ((rd == rs1) || (rd == rs2));
  endfunction

  assign ds_stall = rd_hit(i_es_rd, i_rs1, i_rs2)
                 || rd_hit(i_ms_rd, i_rs1, i_rs2)
                 || rd_hit(i_ws_rd, i_rs1, i_rs2);

  assign o_ds_allowin = !ds_valid || (!ds_stall && i_es_allowin);
  assign o_es_valid   = ds_valid && !ds_stall;

  // no redirect when fetch already sits on the target
  assign o_br_taken   = o_es_valid && i_br_sel && (i_br_target != i_fs_pc);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_valid;
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_ds_inst <= '0;
      o_ds_pc   <= '0;
    end else if (i_fs_valid && o_ds_allowin) begin
      o_ds_inst <= o_br_taken ? '0 : i_fs_inst;  // wrong path word becomes a bubble
      o_ds_pc   <= i_fs_pc;
    end
  end

endmodule

`default_nettype wire

// File: logic/id_pkg.sv
// vector types shared by the decode stage with widths taken from id_cfg.svh
`default_nettype none

`include "id_cfg.svh"

package id_pkg;

  // register value, pc or sign extended immediate
  typedef logic [`ID_XLEN-1:0]       xlen_t;

  typedef logic [`ID_INST_W-1:0]     inst_t;

  typedef logic [`ID_GPR_ADDR_W-1:0] gpr_addr_t;

  // ID_ALU_* codes
  typedef logic [1:0]                alu_op_t;

  typedef logic [6:0]                opcode_t;  // inst[6:0]

endpackage

`default_nettype wire

// File: logic/id_cfg.svh
// encodings cover only the decoded RV64I subset and ld/sd are doubleword only
`ifndef ID_CFG_SVH
`define ID_CFG_SVH

`define ID_XLEN        64
`define ID_INST_W      32
`define ID_GPR_ADDR_W  5
`define ID_NUM_GPRS    32

// major opcodes
`define ID_OPC_OP      7'b0110011
`define ID_OPC_OP_IMM  7'b0010011
`define ID_OPC_LOAD    7'b0000011
`define ID_OPC_STORE   7'b0100011
`define ID_OPC_BRANCH  7'b1100011
`define ID_OPC_JAL     7'b1101111
`define ID_OPC_JALR    7'b1100111

`define ID_F3_BEQ      3'b000
`define ID_F3_BNE      3'b001
`define ID_F3_ADD      3'b000  // also the funct3 of jalr
`define ID_F3_D        3'b011
`define ID_F7_SUB      7'b0100000

`define ID_ALU_ADD     2'd0
`define ID_ALU_SUB     2'd1
`define ID_ALU_LINK    2'd2    // execute writes pc + 4

`endif
